//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = motorDriveTb
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- list.f
+incdir+rtl
rtl/motorPkg.sv
rtl/commutationTimer.sv
rtl/pwmGenerator.sv
rtl/phaseSequencer.sv
rtl/motorDriveTop.sv
tb/motorDrive_sva.sv
tb/motorDriveTb.sv

//--- rtl/commutationTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "motorDefines_defines.svh"

module commutationTimer (
    input  logic                     clk,
    input  logic                     nRst,
    input  logic                     run,
    input  logic [`MOTOR_STEP_W-1:0] stepPeriod,
    output logic                     stepStrobe
);

    // remaining cycles of the current step, zero is the last one
    logic [`MOTOR_STEP_W-1:0] stepCnt;
    logic [`MOTOR_STEP_W-1:0] stepLoad;
    logic                     stepLast;

    // stepPeriod is sampled only here, so a new value waits for the next reload
    assign stepLoad = stepPeriod - 1'b1;
    assign stepLast = (stepCnt == '0);

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            stepCnt    <= '0;
            stepStrobe <= 1'b0;
        end else begin
            if (!run) begin
                // stopped, park at the reload value
                // so the first strobe lands stepPeriod cycles after run rises
                stepCnt    <= stepLoad;
                stepStrobe <= 1'b0;
            end else if (stepLast) begin
                // end of step, one-cycle strobe and start the next step
                stepCnt    <= stepLoad;
                stepStrobe <= 1'b1;
            end else begin
                stepCnt    <= stepCnt - 1'b1;
                stepStrobe <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/motorDefines_defines.svh
`ifndef MOTOR_DEFINES_SVH
`define MOTOR_DEFINES_SVH

// step counter and stepPeriod width
// 25 bits gives over three seconds per step at 10 MHz
`define MOTOR_STEP_W 25

// duty register and pwm on/off counter width
`define MOTOR_DUTY_W 12

// one pwm period in clocks, off time plus on time
// at 10 MHz this is about 51 us, just under 20 kHz
`define MOTOR_PWM_PERIOD 511

// duty code for a high side that never switches off
// any duty at or above this keeps pwm high for the whole step
`define MOTOR_DUTY_FULL `MOTOR_PWM_PERIOD

`endif

//--- rtl/motorDriveTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "motorDefines_defines.svh"

module motorDriveTop (
    input  logic                     clk,
    input  logic                     nRst,
    input  logic                     run,
    input  logic                     dir,
    input  logic [`MOTOR_STEP_W-1:0] stepPeriod,
    input  logic [`MOTOR_DUTY_W-1:0] duty,
    output motorPkg::gateDrive_t     gates
);
    import motorPkg::*;

    // one pulse per commutation step
    logic         stepStrobe;
    // conducting phases, zero when stopped
    phaseEnable_t phaseEn;
    // chopping signal for the active high side
    logic         pwm;

    commutationTimer commutationTimer_i (
        .clk        (clk),
        .nRst       (nRst),
        .run        (run),
        .stepPeriod (stepPeriod),
        .stepStrobe (stepStrobe)
    );

    phaseSequencer phaseSequencer_i (
        .clk        (clk),
        .nRst       (nRst),
        .run        (run),
        .dir        (dir),
        .stepStrobe (stepStrobe),
        .pwm        (pwm),
        .phaseEn    (phaseEn),
        .gates      (gates)
    );

    pwmGenerator pwmGenerator_i (
        .clk        (clk),
        .nRst       (nRst),
        .stepStrobe (stepStrobe),
        .phaseEn    (phaseEn),
        .duty       (duty),
        .pwm        (pwm)
    );

endmodule

`default_nettype wire

//--- rtl/motorPkg.sv
`default_nettype none

package motorPkg;

    // six commutation steps of the trapezoidal sequence
    // forward rotation walks step0 up to step5 and wraps
    typedef enum logic [2:0] {
        step0,
        step1,
        step2,
        step3,
        step4,
        step5
    } stepState_t;

    // one bit per motor phase that conducts in the current step
    // all clear while the drive is stopped
    typedef struct packed {
        logic aE;
        logic bE;
        logic cE;
    } phaseEnable_t;

    // one bit per power switch of the three half bridges
    typedef struct packed {
        logic aHi;
        logic aLo;
        logic bHi;
        logic bLo;
        logic cHi;
        logic cLo;
    } gateDrive_t;

endpackage

`default_nettype wire

//--- rtl/phaseSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
    input  logic                   clk,
    input  logic                   nRst,
    input  logic                   run,
    input  logic                   dir,
    input  logic                   stepStrobe,
    input  logic                   pwm,
    output motorPkg::phaseEnable_t phaseEn,
    output motorPkg::gateDrive_t   gates
);
    import motorPkg::*;

    stepState_t   state;
    stepState_t   stateNext;
    phaseEnable_t phaseEnNext;
    gateDrive_t   gatesNext;

    // step advance, forward when dir is high
    always_comb begin
        stateNext = state;
        if (run && stepStrobe) begin
            if (dir) begin
                case (state)
                    step0:   stateNext = step1;
                    step1:   stateNext = step2;
                    step2:   stateNext = step3;
                    step3:   stateNext = step4;
                    step4:   stateNext = step5;
                    default: stateNext = step0;
                endcase
            end else begin
                case (state)
                    step0:   stateNext = step5;
                    step5:   stateNext = step4;
                    step4:   stateNext = step3;
                    step3:   stateNext = step2;
                    step2:   stateNext = step1;
                    default: stateNext = step0;
                endcase
            end
        end
    end

    // conducting pair of the coming step, cleared once run drops
    always_comb begin
        phaseEnNext = '0;
        if (run) begin
            case (stateNext)
                step0, step3: phaseEnNext = '{aE: 1'b1, bE: 1'b1, cE: 1'b0};
                step1, step4: phaseEnNext = '{aE: 1'b1, bE: 1'b0, cE: 1'b1};
                default:      phaseEnNext = '{aE: 1'b0, bE: 1'b1, cE: 1'b1};
            endcase
        end
    end

    // high side chopped by pwm, low side held on for the whole step
    // each step drives exactly one hi and one lo of two different phases
    always_comb begin
        gatesNext = '0;
        if (phaseEn != '0) begin
            case (state)
                step0: begin
                    gatesNext.aHi = pwm;
                    gatesNext.bLo = 1'b1;
                end
                step1: begin
                    gatesNext.aHi = pwm;
                    gatesNext.cLo = 1'b1;
                end
                step2: begin
                    gatesNext.bHi = pwm;
                    gatesNext.cLo = 1'b1;
                end
                step3: begin
                    gatesNext.bHi = pwm;
                    gatesNext.aLo = 1'b1;
                end
                step4: begin
                    gatesNext.cHi = pwm;
                    gatesNext.aLo = 1'b1;
                end
                step5: begin
                    gatesNext.cHi = pwm;
                    gatesNext.bLo = 1'b1;
                end
                default: gatesNext = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            state   <= step0;
            phaseEn <= '0;
            gates   <= '0;
        end else begin
            state   <= stateNext;
            phaseEn <= phaseEnNext;
            // gates trail state and pwm by one cycle
            gates   <= gatesNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pwmGenerator.sv
`timescale 1ns/1ps
`default_nettype none

`include "motorDefines_defines.svh"

module pwmGenerator (
    input  logic                     clk,
    input  logic                     nRst,
    input  logic                     stepStrobe,
    input  motorPkg::phaseEnable_t   phaseEn,
    input  logic [`MOTOR_DUTY_W-1:0] duty,
    output logic                     pwm
);
    import motorPkg::*;

    localparam logic [`MOTOR_DUTY_W-1:0] pwmPeriod = `MOTOR_DUTY_W'(`MOTOR_PWM_PERIOD);
    localparam logic [`MOTOR_DUTY_W-1:0] dutyFull  = `MOTOR_DUTY_W'(`MOTOR_DUTY_FULL);

    // duty held for the whole step
    logic [`MOTOR_DUTY_W-1:0] dutyReg;
    // cycles left in the current on or off phase
    logic [`MOTOR_DUTY_W-1:0] pwmCnt;

    logic                     idle;
    logic                     reload;
    logic                     cntLast;
    logic                     dutyInFull;
    logic [`MOTOR_DUTY_W-1:0] offLoadIn;
    logic [`MOTOR_DUTY_W-1:0] onLoad;
    logic [`MOTOR_DUTY_W-1:0] offLoad;

    // no conducting phase means the bridge is parked
    assign idle   = (phaseEn == '0);
    assign reload = stepStrobe || idle;

    // counter holds 1 on the last cycle of a phase
    assign cntLast = (pwmCnt == `MOTOR_DUTY_W'(1));

    // off time of the incoming duty, used on the reload cycle itself
    assign dutyInFull = (duty >= dutyFull);
    assign offLoadIn  = pwmPeriod - duty;

    // on and off times of the latched duty, they sum to one pwm period
    assign onLoad  = dutyReg;
    assign offLoad = pwmPeriod - dutyReg;

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            dutyReg <= '0;
        end else if (reload) begin
            // new duty is only taken at a step boundary or while stopped
            dutyReg <= duty;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            pwmCnt <= pwmPeriod;
            pwm    <= 1'b0;
        end else begin
            if (reload) begin
                // every step starts with the off phase
                // full duty goes straight high, but never while stopped
                pwmCnt <= offLoadIn;
                pwm    <= !idle && dutyInFull;
            end else if (dutyReg >= dutyFull) begin
                pwm <= 1'b1;
            end else if (dutyReg == '0) begin
                // zero duty, counter is left frozen
                pwm <= 1'b0;
            end else if (cntLast) begin
                // swap phases, load the length of the one being entered
                if (pwm) begin
                    pwmCnt <= offLoad;
                end else begin
                    pwmCnt <= onLoad;
                end
                pwm <= ~pwm;
            end else begin
                pwmCnt <= pwmCnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/motorDriveTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "motorDefines_defines.svh"

module motorDriveTb;
    import motorPkg::*;

    // longest step the stimulus picks, four pwm periods plus a random share
    localparam int maxPeriod     = 4 * `MOTOR_PWM_PERIOD + 1023;
    // forward 7, reverse 7, zero duty 3, full duty 3
    localparam int totalSteps    = 20;
    localparam int timeoutCycles = (totalSteps + 4) * maxPeriod + 1000;

    logic                     clk;
    logic                     nRst;
    logic                     run;
    logic                     dir;
    logic [`MOTOR_STEP_W-1:0] stepPeriod;
    logic [`MOTOR_DUTY_W-1:0] duty;
    gateDrive_t               gates;

    logic [31:0] lfsrState  = 32'he4c6_6f33;
    string       testName   = "reset";
    int          cycleCount = 0;
    // model values as they stand after each rising edge
    gateDrive_t  expGates   = '0;
    logic        mActive    = 1'b0;
    int          mStep      = 0;
    int          mPos       = 0;
    int          mDuty      = 0;

    motorDriveTop motorDriveTop_i (
        .clk        (clk),
        .nRst       (nRst),
        .run        (run),
        .dir        (dir),
        .stepPeriod (stepPeriod),
        .duty       (duty),
        .gates      (gates)
    );

    // fibonacci lfsr with taps 32 22 2 1, one step per bit taken
    function automatic int takeBits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            val = (val << 1) | int'(lfsrState[0]);
        end
        return val;
    endfunction

    // each period starts with the off time, then duty cycles high
    function automatic logic hiOn(input int pos, input int d);
        if (d >= `MOTOR_DUTY_FULL) begin
            return 1'b1;
        end else begin
            return (pos % `MOTOR_PWM_PERIOD) >= (`MOTOR_PWM_PERIOD - d);
        end
    endfunction

    // high side walks A A B B C C, low side runs B C C A A B
    function automatic gateDrive_t gatesFor(input int step, input logic hi);
        gateDrive_t g;
        int         hiPhase;
        int         loPhase;
        hiPhase = step / 2;
        loPhase = ((step + 1) / 2 + 1) % 3;
        g.aHi = hi && (hiPhase == 0);
        g.aLo = (loPhase == 0);
        g.bHi = hi && (hiPhase == 1);
        g.bLo = (loPhase == 1);
        g.cHi = hi && (hiPhase == 2);
        g.cLo = (loPhase == 2);
        return g;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // period and direction only change while stopped
    // duty changes mid step and must wait for the next boundary
    task automatic runTest(input string name, input logic dirVal, input int steps,
                           input int midDuty);
        int period;
        testName   = name;
        period     = 4 * `MOTOR_PWM_PERIOD + takeBits(10);
        #1 dir     = dirVal;
        stepPeriod = `MOTOR_STEP_W'(period);
        duty       = `MOTOR_DUTY_W'(takeBits(9) % `MOTOR_PWM_PERIOD);
        repeat (4) @(posedge clk);
        #1 run = 1'b1;
        for (int s = 0; s < steps; s++) begin
            repeat (period / 2) @(posedge clk);
            #1 duty = (midDuty < 0) ? `MOTOR_DUTY_W'(takeBits(9)) : `MOTOR_DUTY_W'(midDuty);
            repeat (period - period / 2) @(posedge clk);
        end
        // stop partway into a step, gates clear and the step holds
        repeat (period / 3) @(posedge clk);
        testName = {name, "Stop"};
        #1 run = 1'b0;
        repeat (8) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        nRst       = 1'b1;
        run        = 1'b0;
        dir        = 1'b0;
        stepPeriod = `MOTOR_STEP_W'(maxPeriod);
        duty       = '0;
        // clean falling edge for the asynchronous reset
        #1 nRst = 1'b0;
        repeat (16) @(posedge clk);
        #1 nRst = 1'b1;
        repeat (8) @(posedge clk);
        runTest("forward", 1'b1, 7, -1);
        runTest("reverse", 1'b0, 7, -1);
        runTest("zeroDuty", 1'b1, 3, 0);
        runTest("fullDuty", 1'b0, 3, `MOTOR_DUTY_FULL);
        $display("Test passed");
        $finish;
    end

    // reference model, gates trail the step state by one edge
    always @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            expGates = '0;
            mActive  = 1'b0;
            mStep    = 0;
            mPos     = 0;
        end else begin
            expGates = mActive ? gatesFor(mStep, hiOn(mPos, mDuty)) : '0;
            if (!run) begin
                mActive = 1'b0;
            end else if (!mActive) begin
                // first running edge opens a step at the held position
                mActive = 1'b1;
                mPos    = 0;
                mDuty   = int'(duty);
            end else if (mPos == int'(stepPeriod) - 1) begin
                mPos  = 0;
                mDuty = int'(duty);
                mStep = dir ? (mStep + 1) % 6 : (mStep + 5) % 6;
            end else begin
                mPos = mPos + 1;
            end
        end
    end

    // compare on the falling edge where gates are settled
    // checked from the first clock of reset on
    always @(negedge clk) begin
        if (cycleCount > 0) begin
            assert (gates === expGates)
                else abortRun($sformatf("mismatch %s expected %h actual %h",
                                        testName, expGates, gates));
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            abortRun($sformatf("run did not finish within %0d cycles", timeoutCycles));
        end
    end

endmodule

`default_nettype wire

//--- tb/motorDrive_sva.sv
`timescale 1ns/1ps
`default_nettype none

module motorDriveSva (
    input logic                 clk,
    input logic                 nRst,
    input logic                 run,
    input motorPkg::gateDrive_t gates
);

    // all switches open while reset is held
    resetGatesOff: assert property (@(posedge clk) !nRst |-> gates == '0)
        else $error("gates active during reset");

    // run low opens every switch two edges later
    stopGatesOff: assert property (@(posedge clk) disable iff (!nRst)
        !$past(run, 2) |-> gates == '0)
        else $error("gates active after run went low");

    // a half bridge never shoots through
    noShootThrough: assert property (@(posedge clk)
        !(gates.aHi && gates.aLo) && !(gates.bHi && gates.bLo) && !(gates.cHi && gates.cLo))
        else $error("high and low side of one phase on together");

    // only one return path at a time
    oneLowSide: assert property (@(posedge clk)
        $countones({gates.aLo, gates.bLo, gates.cLo}) <= 1)
        else $error("more than one low side switch on");

endmodule

bind motorDriveTop motorDriveSva motorDriveSva_i (
    .clk   (clk),
    .nRst  (nRst),
    .run   (run),
    .gates (gates)
);

`default_nettype wire
